// ==== audioClockPkg.sv ====
/*
  Constants for the audio clock domain reset sequencing
  Lock is taken as a plain level, already synchronous to wAudioClk
  lockSettleCycles must be at least 2 and must fit in settleCount
*/
`default_nettype none

package audioClockPkg;

    //--------------------------------------------------
    // Lock settling
    //--------------------------------------------------

    // Consecutive locked cycles before the domain is released
    localparam int lockSettleCycles = 16;

    // Counter width, holds lockSettleCycles itself
    localparam int settleBits = 5;
    typedef logic [settleBits-1:0] settleCount;

    // Reset sequencer states
    typedef enum logic [1:0]
    {
        held,
        settling,
        running
    } resetState;

endpackage

`default_nettype wire

// ==== audioDataPkg.sv ====
/*
  Audio sample, gain and PWM duty definitions
  Samples are signed PCM, duty is offset binary
  Volume is a linear gain in sixteenths, 0 mutes
  One PWM frame is 2**dutyBits cycles of wAudioClk
*/
`default_nettype none

package audioDataPkg;

    //--------------------------------------------------
    // Widths
    //--------------------------------------------------
    localparam int sampleBits  = 16;
    localparam int volumeBits  = 4;
    localparam int dutyBits    = 8;
    // Sample times zero-extended volume
    localparam int productBits = sampleBits + volumeBits + 1;
    // Gain is in sixteenths
    localparam int volumeShift = 4;

    typedef logic signed [sampleBits-1:0]  sampleWord;
    typedef logic [volumeBits-1:0]         volumeLevel;
    typedef logic [dutyBits-1:0]           dutyCode;
    typedef logic [dutyBits-1:0]           frameCount;
    typedef logic signed [productBits-1:0] scaleProduct;

    // Mid-scale duty, zero output level
    localparam dutyCode silenceDuty = 8'd128;

    //--------------------------------------------------
    // Scaler to modulator beat
    //--------------------------------------------------
    typedef struct packed
    {
        // High cycles per frame
        dutyCode duty;
        // One-cycle pulse on a new duty
        logic    fresh;
    } dutyBeat;

endpackage

`default_nettype wire

// ==== audioResetGen.sv ====
/*
  Lock-qualified reset for the audio domain
  pllLocked is expected synchronous to wAudioClk
  audioRst rises one edge after reset or a lock drop is seen
  and falls only after lockSettleCycles clean locked cycles
*/
`default_nettype none

module audioResetGen
(
    input  wire logic wAudioClk,
    input  wire logic reset,
    input  wire logic pllLocked,
    output logic      audioRst,
    output logic      audioReady
);

    audioClockPkg::resetState  state;
    audioClockPkg::settleCount lockCount;

    //--------------------------------------------------
    // Settling sequencer
    //--------------------------------------------------
    always_ff @(posedge wAudioClk)
    begin
        // Any dirty cycle restarts the whole sequence
        if (reset || !pllLocked)
        begin
            state      <= audioClockPkg::held;
            lockCount  <= '0;
            audioRst   <= 1'b1;
            audioReady <= 1'b0;
        end
        else
        begin
            case (state)
                audioClockPkg::held:
                begin
                    // First clean cycle just completed
                    state     <= audioClockPkg::settling;
                    lockCount <= audioClockPkg::settleCount'(1);
                end
                audioClockPkg::settling:
                begin
                    // Last settling cycle, release on this edge
                    if (lockCount == audioClockPkg::settleCount'(
                            audioClockPkg::lockSettleCycles - 1))
                    begin
                        state      <= audioClockPkg::running;
                        lockCount  <= audioClockPkg::settleCount'(
                                          audioClockPkg::lockSettleCycles);
                        audioRst   <= 1'b0;
                        audioReady <= 1'b1;
                    end
                    else
                    begin
                        lockCount <= lockCount + 1'b1;
                    end
                end
                audioClockPkg::running:
                begin
                    // Stay released while lock holds
                    audioRst   <= 1'b0;
                    audioReady <= 1'b1;
                end
                default:
                begin
                    state <= audioClockPkg::held;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== sampleScaler.sv ====
/*
  Volume scaler and duty converter
  sampleData and volume are sampled together on sampleValid
  Scaling floors toward minus infinity, then the top byte
  is turned into an offset-binary PWM duty
  beat follows sampleValid by one cycle
*/
`default_nettype none

module sampleScaler
(
    input  wire logic                     wAudioClk,
    input  wire logic                     audioRst,
    input  wire logic                     sampleValid,
    input  wire audioDataPkg::sampleWord  sampleData,
    input  wire audioDataPkg::volumeLevel volume,
    output audioDataPkg::dutyBeat         beat
);

    audioDataPkg::scaleProduct product;
    audioDataPkg::sampleWord   scaled;
    audioDataPkg::dutyCode     codeBits;
    audioDataPkg::dutyCode     dutyNext;

    //--------------------------------------------------
    // Gain and duty mapping
    //--------------------------------------------------

    // Volume is unsigned, widen with a zero sign bit
    assign product = sampleData * $signed({1'b0, volume});

    // Arithmetic shift gives the floor of product / 16
    assign scaled = audioDataPkg::sampleWord'(product >>> audioDataPkg::volumeShift);

    // Top byte of the scaled sample
    assign codeBits = scaled[audioDataPkg::sampleBits-1 -: audioDataPkg::dutyBits];

    // Two's complement to offset binary
    // 0x80 becomes 0, 0x00 becomes 128, 0x7F becomes 255
    assign dutyNext = {~codeBits[audioDataPkg::dutyBits-1],
                       codeBits[audioDataPkg::dutyBits-2:0]};

    //--------------------------------------------------
    // Output beat
    //--------------------------------------------------
    always_ff @(posedge wAudioClk)
    begin
        if (audioRst)
        begin
            // Park at mid-scale
            beat.duty  <= audioDataPkg::silenceDuty;
            beat.fresh <= 1'b0;
        end
        else
        begin
            // Fresh pulse mirrors the strobe one cycle later
            beat.fresh <= sampleValid;
            if (sampleValid)
            begin
                beat.duty <= dutyNext;
            end
        end
    end

endmodule

`default_nettype wire

// ==== pwmModulator.sv ====
/*
  Single-pin PWM modulator
  Frame is 256 cycles, duty reloads only at frame start
  sampleRequest and pwmOut come from the same register stage,
  so each output frame starts on a request pulse
  Both outputs are forced low while audioRst is high
  A newer beat simply overwrites the pending duty
*/
`default_nettype none

module pwmModulator
(
    input  wire logic                  wAudioClk,
    input  wire logic                  audioRst,
    input  wire audioDataPkg::dutyBeat beat,
    output logic                       pwmOut,
    output logic                       sampleRequest
);

    audioDataPkg::frameCount framePos;
    audioDataPkg::dutyCode   pendingDuty;
    audioDataPkg::dutyCode   activeDuty;
    audioDataPkg::dutyCode   frameDuty;
    logic                    frameStart;
    // Registered pin and request before the reset gate
    logic                    pwmBit;
    logic                    requestBit;

    //--------------------------------------------------
    // Frame position decode
    //--------------------------------------------------
    assign frameStart = (framePos == '0);

    // At position 0 the active copy is not loaded yet
    assign frameDuty = frameStart ? pendingDuty : activeDuty;

    //--------------------------------------------------
    // Pending duty
    //--------------------------------------------------
    always_ff @(posedge wAudioClk)
    begin
        if (audioRst)
        begin
            // Silence until the first beat
            pendingDuty <= audioDataPkg::silenceDuty;
        end
        else if (beat.fresh)
        begin
            pendingDuty <= beat.duty;
        end
    end

    //--------------------------------------------------
    // Active duty, copied once per frame
    //--------------------------------------------------
    always_ff @(posedge wAudioClk)
    begin
        if (frameStart)
        begin
            activeDuty <= pendingDuty;
        end
    end

    //--------------------------------------------------
    // Frame counter and outputs
    //--------------------------------------------------
    always_ff @(posedge wAudioClk)
    begin
        if (audioRst)
        begin
            // Counter parked at frame start
            framePos   <= '0;
            requestBit <= 1'b0;
            pwmBit     <= 1'b0;
        end
        else
        begin
            // Wraps from 255 back to 0
            framePos   <= framePos + 1'b1;
            // One request per frame
            requestBit <= frameStart;
            // High for exactly frameDuty cycles
            pwmBit     <= (framePos < frameDuty);
        end
    end

    // Pin drops on the same edge that raises audioRst
    assign pwmOut        = pwmBit & ~audioRst;
    assign sampleRequest = requestBit & ~audioRst;

endmodule

`default_nettype wire

// ==== audioPwmTop.sv ====
/*
  Audio PWM path top level
  pllLocked stands in for the clock manager lock output
  The sample source answers each sampleRequest with one
  sampleValid strobe before the next request
  A strobed sample sets the high time of the next frame
*/
`default_nettype none

module audioPwmTop
(
    input  wire logic                     wAudioClk,
    input  wire logic                     reset,
    input  wire logic                     pllLocked,
    input  wire logic                     sampleValid,
    input  wire audioDataPkg::sampleWord  sampleData,
    input  wire audioDataPkg::volumeLevel volume,
    output logic                          pwmOut,
    output logic                          sampleRequest,
    output logic                          audioReady
);

    // Domain reset from the lock qualifier
    logic                  audioRst;
    // Duty handoff, scaler to modulator
    audioDataPkg::dutyBeat beat;

    //--------------------------------------------------
    // Reset generation
    //--------------------------------------------------
    audioResetGen resetGen
    (
        .wAudioClk  (wAudioClk),
        .reset      (reset),
        .pllLocked  (pllLocked),
        .audioRst   (audioRst),
        .audioReady (audioReady)
    );

    //--------------------------------------------------
    // Sample scaling
    //--------------------------------------------------
    sampleScaler scaler
    (
        .wAudioClk   (wAudioClk),
        .audioRst    (audioRst),
        .sampleValid (sampleValid),
        .sampleData  (sampleData),
        .volume      (volume),
        .beat        (beat)
    );

    //--------------------------------------------------
    // PWM output
    //--------------------------------------------------
    pwmModulator modulator
    (
        .wAudioClk     (wAudioClk),
        .audioRst      (audioRst),
        .beat          (beat),
        .pwmOut        (pwmOut),
        .sampleRequest (sampleRequest)
    );

endmodule

`default_nettype wire

// ==== tbClockGen.sv ====
/*
  Free-running testbench clock for wAudioClk
  Period is 20 ns, starts low, first rising edge at 10 ns
*/
`default_nettype none

module tbClockGen
(
    output logic wAudioClk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        wAudioClk = 1'b0;
        // Half period of 10 ns
        forever
        begin
            #10 wAudioClk = ~wAudioClk;
        end
    end

endmodule

`default_nettype wire

// ==== audioPwmTb.sv ====
/*
  Self-checking testbench for the audio PWM path
  Vectors come from audioTests.txt, read from the project root
  Expected duty in the file is floor(sample * volume / 4096) + 128
  Inputs change 1 ns after the rising edge, outputs are read there too
  Immediate assertions need assertion support enabled in the simulator
  The run stops after 40 + 768 cycles per test vector
*/
`default_nettype none

module audioPwmTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int frameLength    = 256;
    localparam int settleCycles   = 16;
    localparam int resetCycles    = 5;
    localparam int lockWaitCycles = 4;
    localparam int silence        = 128;

    logic                     wAudioClk;
    logic                     reset;
    logic                     pllLocked;
    logic                     sampleValid;
    audioDataPkg::sampleWord  sampleData;
    audioDataPkg::volumeLevel volume;
    logic                     pwmOut;
    logic                     sampleRequest;
    logic                     audioReady;

    // One entry per vector line
    int flagList[$];
    int sampleList[$];
    int volumeList[$];
    int dutyList[$];

    int errorCount;
    int checkCount;
    int cycleCount;
    int cycleLimit;
    // Duty the DUT is expected to hold right now
    int lastDuty;

    tbClockGen clockGen
    (
        .wAudioClk (wAudioClk)
    );

    audioPwmTop uut
    (
        .wAudioClk     (wAudioClk),
        .reset         (reset),
        .pllLocked     (pllLocked),
        .sampleValid   (sampleValid),
        .sampleData    (sampleData),
        .volume        (volume),
        .pwmOut        (pwmOut),
        .sampleRequest (sampleRequest),
        .audioReady    (audioReady)
    );

    //--------------------------------------------------
    // Helpers
    //--------------------------------------------------

    // Step to just after the next rising edge
    task automatic nextCycle;
        @(posedge wAudioClk);
        #1;
    endtask

    task automatic checkValue(input string signalName, input int expected, input int actual);
        checkCount++;
        assert (actual == expected)
        else
        begin
            errorCount++;
            $display("FAIL at %0t: %s expected %0d, got %0d",
                     $time, signalName, expected, actual);
        end
    endtask

    task automatic loadTests;
        int    fd;
        int    fields;
        int    flagVal;
        int    sampleVal;
        int    volumeVal;
        int    dutyVal;
        string lineText;
        fd = $fopen("audioTests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open audioTests.txt for reading");
            return;
        end
        while (!$feof(fd))
        begin
            lineText = "";
            if ($fgets(lineText, fd) > 0)
            begin
                // Comment and blank lines do not scan four fields
                fields = $sscanf(lineText, "%h %h %d %d",
                                 flagVal, sampleVal, volumeVal, dutyVal);
                if (fields == 4)
                begin
                    flagList.push_back(flagVal);
                    sampleList.push_back(sampleVal);
                    volumeList.push_back(volumeVal);
                    dutyList.push_back(dutyVal);
                end
            end
        end
        $fclose(fd);
    endtask

    // Called right after pllLocked goes high
    task automatic checkRelease;
        for (int k = 1; k <= settleCycles; k++)
        begin
            nextCycle;
            checkValue("audioReady", (k == settleCycles) ? 1 : 0, audioReady);
            checkValue("pwmOut", 0, pwmOut);
            checkValue("sampleRequest", 0, sampleRequest);
        end
        // First frame opens on the first released cycle
        nextCycle;
        checkValue("sampleRequest", 1, sampleRequest);
    endtask

    // Starts on a request cycle, ends on the next one
    task automatic measureFrame(input bit doStrobe, input int sampleVal, input int volumeVal,
                                output int highCount, output int frameLen);
        bit frameDone;
        highCount = pwmOut ? 1 : 0;
        frameLen  = 1;
        frameDone = 1'b0;
        while (!frameDone)
        begin
            nextCycle;
            // Answer the request on the following cycle
            if (doStrobe && frameLen == 1)
            begin
                sampleValid = 1'b1;
                sampleData  = audioDataPkg::sampleWord'(sampleVal);
                volume      = audioDataPkg::volumeLevel'(volumeVal);
            end
            else
            begin
                sampleValid = 1'b0;
            end
            if (sampleRequest)
            begin
                frameDone = 1'b1;
            end
            else if (frameLen >= 2 * frameLength)
            begin
                errorCount++;
                $display("No sampleRequest came within %0d cycles of the previous one",
                         2 * frameLength);
                frameDone = 1'b1;
            end
            else
            begin
                if (pwmOut)
                begin
                    highCount++;
                end
                frameLen++;
            end
        end
    endtask

    task automatic checkFrame(input bit doStrobe, input int sampleVal, input int volumeVal,
                              input int expected, input string label);
        int highCount;
        int frameLen;
        measureFrame(doStrobe, sampleVal, volumeVal, highCount, frameLen);
        checkValue({"frame length, ", label}, frameLength, frameLen);
        checkValue({"pwmOut high cycles, ", label}, expected, highCount);
    endtask

    //--------------------------------------------------
    // Sequences
    //--------------------------------------------------
    task automatic bringUp;
        repeat (resetCycles)
        begin
            nextCycle;
            checkValue("audioReady", 0, audioReady);
            checkValue("pwmOut", 0, pwmOut);
            checkValue("sampleRequest", 0, sampleRequest);
        end
        reset = 1'b0;
        // Out of reset, still unlocked
        repeat (lockWaitCycles)
        begin
            nextCycle;
            checkValue("audioReady", 0, audioReady);
            checkValue("pwmOut", 0, pwmOut);
            checkValue("sampleRequest", 0, sampleRequest);
        end
        pllLocked = 1'b1;
        checkRelease;
        checkFrame(1'b0, 0, 0, silence, "silence after release");
        lastDuty = silence;
    endtask

    // One cycle without lock, then a full re-release
    task automatic dropLock(input string label);
        pllLocked = 1'b0;
        nextCycle;
        // Domain and pin both go down on the edge after the drop
        checkValue("audioReady", 0, audioReady);
        checkValue("pwmOut", 0, pwmOut);
        checkValue("sampleRequest", 0, sampleRequest);
        pllLocked = 1'b1;
        checkRelease;
        checkFrame(1'b0, 0, 0, silence, {label, ", silence after relock"});
        lastDuty = silence;
    endtask

    task automatic runTest(input int index);
        string label;
        label = $sformatf("test %0d", index + 1);
        if (flagList[index] & 1)
        begin
            dropLock(label);
        end
        if (flagList[index] & 2)
        begin
            // No strobe, loaded duty repeats
            checkFrame(1'b0, 0, 0, dutyList[index], {label, ", hold"});
        end
        else
        begin
            // Strobe frame still plays the older duty
            checkFrame(1'b1, sampleList[index], volumeList[index], lastDuty,
                       {label, ", strobe frame"});
            checkFrame(1'b0, 0, 0, dutyList[index], {label, ", new duty"});
        end
        lastDuty = dutyList[index];
    endtask

    //--------------------------------------------------
    // Watchdog
    //--------------------------------------------------
    always @(posedge wAudioClk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit)
        begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
            $display("Testbench failed");
            $finish;
        end
    end

    //--------------------------------------------------
    // Main sequence
    //--------------------------------------------------
    initial
    begin
        reset       = 1'b1;
        pllLocked   = 1'b0;
        sampleValid = 1'b0;
        sampleData  = '0;
        volume      = '0;
        errorCount  = 0;
        checkCount  = 0;
        cycleCount  = 0;
        cycleLimit  = 0;
        lastDuty    = silence;
        loadTests();
        if (flagList.size() == 0)
        begin
            $display("No test vectors were read from audioTests.txt");
            errorCount++;
        end
        else
        begin
            cycleLimit = 40 + 3 * frameLength * flagList.size();
            bringUp();
            for (int i = 0; i < flagList.size(); i++)
            begin
                runTest(i);
            end
        end
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== audioTests.txt ====
// Columns: flags (hex), sample (hex), volume (0 to 15), expected duty (decimal)
// Flags: 0 strobe the sample, 1 drop lock one cycle first, 2 hold with no strobe
// Duty = floor(sample * volume / 4096) + 128, sample as signed 16 bits
0 7FFF 15 247  // 32767*15 = 491505, /4096 floors to 119
0 0000 15 128  // zero sits at mid-scale
0 8000 15 8    // -32768*15/4096 is exactly -120
2 0000 0  8    // no strobe, 8 repeats
0 4000 15 188  // 16384*15/4096 = 60
0 C000 15 68   // -16384*15/4096 = -60
0 0001 15 128  // 15/4096 floors to 0
0 FFFF 15 127  // -15/4096 floors to -1
0 1234 15 145  // 4660*15 = 69900, floors to 17
0 0FFF 15 142  // 4095*15 = 61425, floors to 14
0 F000 15 113  // -4096*15/4096 = -15
0 8001 15 8    // -32767*15 = -491505, floors to -120
0 FFF0 15 127  // -16*15 = -240, floors to -1
0 0100 15 128  // 256*15 = 3840, floors to 0
0 7FFF 0  128  // muted
0 7FFF 8  191  // 32767*8 = 262136, floors to 63
0 7FFF 15 247  // nearly full code again
0 8000 8  64   // -32768*8/4096 = -64
0 8000 0  128  // muted negative full scale
2 0000 0  128  // hold after mute
0 7FFF 1  135  // 32767/4096 floors to 7
0 C000 15 68   // non-silent duty ahead of the lock drop
1 4000 15 188  // relock gives 128, then 60 + 128
2 0000 0  188  // hold across a quiet frame
1 0000 15 128  // second lock drop, zero sample after
0 6000 15 218  // 24576*15/4096 = 90

// ==== build.f ====
audioClockPkg.sv
audioDataPkg.sv
audioResetGen.sv
sampleScaler.sv
pwmModulator.sv
audioPwmTop.sv
tbClockGen.sv
audioPwmTb.sv

// ==== build.sh ====
#!/usr/bin/env bash
# Compile and run the audio PWM testbench with Verilator.
# Pass or fail comes from the pass message in the simulation log.

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module audioPwmTb -f build.f -o simAudioPwm
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/simAudioPwm > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Testbench passed" "$logFile"; then
    exit 0
fi
exit 1
